// ==== rtl/prefetcher_macros.svh ====
/* prefetcher sizing constants: queue depth, block size, address and watchdog widths,
   almost-full spacer */
`ifndef PREFETCHER_MACROS_SVH
`define PREFETCHER_MACROS_SVH

// queue holds 2^3 = 8 entries
`define PF_LOG_QUEUE_SIZE 3
`define PF_QUEUE_SIZE (1 << `PF_LOG_QUEUE_SIZE)
// 8-byte blocks, so one block is 64 bits of data
`define PF_LOG_BLOCK_BYTES 3
`define PF_BLOCK_BYTES (1 << `PF_LOG_BLOCK_BYTES)
`define PF_DATA_WIDTH (8 * `PF_BLOCK_BYTES)
`define PF_ADDR_WIDTH 32
`define PF_WATCHDOG_WIDTH 10
// allocation refused once only this many slots remain free
`define PF_ALMOST_FULL_SPACER 1

`endif

// ==== rtl/prefetcherPkg.sv ====
/* prefetcher types: address, data, index and count vectors, port structs and
   the issuer FSM states */
`include "prefetcher_macros.svh"

package prefetcherPkg;

    // byte address, always block aligned
    typedef logic [`PF_ADDR_WIDTH-1:0] blockAddr_t;
    // one full block of data
    typedef logic [`PF_DATA_WIDTH-1:0] blockData_t;
    typedef logic [`PF_LOG_QUEUE_SIZE-1:0] queueIdx_t;
    // one extra bit so a full queue can be counted
    typedef logic [`PF_LOG_QUEUE_SIZE:0] queueCnt_t;
    typedef logic [`PF_WATCHDOG_WIDTH-1:0] prescale_t;

    typedef struct packed {
        blockAddr_t addr;
    } cpuReq_t;

    // hit with dataValid low means the block is still outstanding
    typedef struct packed {
        logic       hit;
        logic       dataValid;
        blockData_t data;
    } lookupResp_t;

    typedef struct packed {
        blockAddr_t addr;
        blockData_t data;
    } dramFill_t;

    typedef enum logic [1:0] {IDLE, ALLOC, SEND} issuerState_e;

endpackage

// ==== rtl/findValueIdx.sv ====
/* findValueIdx: parallel tag compare over a valid vector, hit flag and lowest index */
`timescale 1ns/100ps

module findValueIdx #(
    parameter int LOG_VEC_SIZE = 3
) (
    input  prefetcherPkg::blockAddr_t                          inTag,
    input  prefetcherPkg::blockAddr_t [(1<<LOG_VEC_SIZE)-1:0]  tagMat,
    input  logic [(1<<LOG_VEC_SIZE)-1:0]                       validVec,
    output logic                                               hit,
    output prefetcherPkg::queueIdx_t                           matchIdx
);
    import prefetcherPkg::*;

    localparam int VEC_SIZE = 1 << LOG_VEC_SIZE;

    logic [VEC_SIZE-1:0] matchVec;

    always_comb begin
        matchIdx = '0;
        // scan from the top so the lowest matching index is the one left
        for (int i = VEC_SIZE - 1; i >= 0; i--) begin
            matchVec[i] = validVec[i] && (tagMat[i] == inTag);
            if (matchVec[i]) begin
                matchIdx = queueIdx_t'(i);
            end
        end
        hit = |matchVec;
    end

    // queue never allocates a duplicate, so at most one valid entry may match
    oneMatch: assert final ($onehot0(matchVec));

endmodule

// ==== rtl/watchdogTimer.sv ====
/* watchdogTimer: prescaled down-counter producing a one-cycle eviction tick */
`timescale 1ns/100ps

module watchdogTimer (
    input  logic                     clk,
    input  logic                     resetN,
    input  prefetcherPkg::prescale_t prescale,
    output logic                     tick
);
    import prefetcherPkg::*;

    prescale_t count;

    // period is prescale+1 cycles, tick registered on the wrap
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            count <= '0;
            tick <= 1'b0;
        end else if (count == '0) begin
            count <= prescale;
            tick <= 1'b1;
        end else begin
            count <= count - 1'b1;
            tick <= 1'b0;
        end
    end

    // the reload value seen at the tick decides whether the next cycle can tick too
    tickSingle: assert property (@(posedge clk) disable iff (!resetN)
        tick && ($past(prescale) != '0) |=> !tick);

endmodule

// ==== rtl/prefetcherQueue.sv ====
/* prefetcherQueue: entry storage with head/tail pointers, lookup with pop or flush,
   allocation, fill, snoop invalidate, watchdog eviction and occupancy counters */
`timescale 1ns/100ps
`include "prefetcher_macros.svh"

module prefetcherQueue (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       lookupValid,
    input  prefetcherPkg::blockAddr_t  lookupAddr,
    output prefetcherPkg::lookupResp_t lookupResp,
    output logic                       lookupRespValid,
    input  logic                       allocValid,
    input  prefetcherPkg::blockAddr_t  allocAddr,
    output logic                       allocReady,
    output logic                       allocDup,
    input  logic                       fillValid,
    input  prefetcherPkg::dramFill_t   fill,
    input  logic                       invalValid,
    input  prefetcherPkg::blockAddr_t  invalAddr,
    input  prefetcherPkg::prescale_t   watchdogPrescale,
    output prefetcherPkg::queueCnt_t   outstandingReqCnt,
    output logic                       almostFull
);
    import prefetcherPkg::*;

    localparam int QUEUE_SIZE = `PF_QUEUE_SIZE;

    // per-entry flags
    logic [QUEUE_SIZE-1:0] validVec;
    logic [QUEUE_SIZE-1:0] dataValidVec;
    logic [QUEUE_SIZE-1:0] outstandingVec;
    logic [QUEUE_SIZE-1:0] ageVec;
    logic [QUEUE_SIZE-1:0] validNext;
    logic [QUEUE_SIZE-1:0] dataValidNext;
    logic [QUEUE_SIZE-1:0] outstandingNext;
    logic [QUEUE_SIZE-1:0] ageNext;
    // entries at or after the hit entry survive a pop
    logic [QUEUE_SIZE-1:0] keepMask;
    blockAddr_t [QUEUE_SIZE-1:0] addrMat;
    blockData_t dataMat [QUEUE_SIZE];
    queueIdx_t headPtr;
    queueIdx_t tailPtr;
    queueCnt_t validCnt;
    logic lookupHit;
    logic allocHit;
    logic fillHit;
    logic invalHit;
    queueIdx_t lookupIdx;
    queueIdx_t fillIdx;
    queueIdx_t invalIdx;
    logic allocCreate;
    logic isFull;
    logic wdTick;

    findValueIdx #(.LOG_VEC_SIZE(`PF_LOG_QUEUE_SIZE)) u_lookupFind (
        .inTag(lookupAddr), .tagMat(addrMat), .validVec(validVec),
        .hit(lookupHit), .matchIdx(lookupIdx));
    // only the hit is needed for the duplicate check
    findValueIdx #(.LOG_VEC_SIZE(`PF_LOG_QUEUE_SIZE)) u_allocFind (
        .inTag(allocAddr), .tagMat(addrMat), .validVec(validVec),
        .hit(allocHit), .matchIdx());
    findValueIdx #(.LOG_VEC_SIZE(`PF_LOG_QUEUE_SIZE)) u_fillFind (
        .inTag(fill.addr), .tagMat(addrMat), .validVec(validVec),
        .hit(fillHit), .matchIdx(fillIdx));
    findValueIdx #(.LOG_VEC_SIZE(`PF_LOG_QUEUE_SIZE)) u_invalFind (
        .inTag(invalAddr), .tagMat(addrMat), .validVec(validVec),
        .hit(invalHit), .matchIdx(invalIdx));

    watchdogTimer u_watchdog (
        .clk(clk), .resetN(resetN), .prescale(watchdogPrescale), .tick(wdTick));

    always_comb begin
        validCnt = '0;
        outstandingReqCnt = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            validCnt = validCnt + queueCnt_t'(validVec[i]);
            outstandingReqCnt = outstandingReqCnt + queueCnt_t'(outstandingVec[i]);
            // distance from head, wrapping on the index width
            keepMask[i] = (queueIdx_t'(i) - headPtr) >= (lookupIdx - headPtr);
        end
    end

    assign almostFull = validCnt >= queueCnt_t'(QUEUE_SIZE - `PF_ALMOST_FULL_SPACER);
    assign allocReady = !almostFull;
    assign allocDup = allocHit;
    // a duplicate is acknowledged but makes no entry
    assign allocCreate = allocValid && allocReady && !allocHit;
    assign isFull = validVec[tailPtr];

    // updates applied lowest priority first, later ones override
    always_comb begin
        validNext = validVec;
        dataValidNext = dataValidVec;
        outstandingNext = outstandingVec;
        ageNext = ageVec;
        // evict what was already aged, then age everything
        if (wdTick) begin
            validNext = validVec & ~ageVec;
            ageNext = '1;
        end
        if (invalValid && invalHit) begin
            dataValidNext[invalIdx] = 1'b0;
        end
        // miss means the stream broke
        if (lookupValid) begin
            validNext = lookupHit ? (validNext & keepMask) : '0;
        end
        // dropped entries lose their flags too
        dataValidNext = dataValidNext & validNext;
        outstandingNext = outstandingNext & validNext;
        if (allocCreate) begin
            validNext[tailPtr] = 1'b1;
            dataValidNext[tailPtr] = 1'b0;
            outstandingNext[tailPtr] = 1'b1;
            ageNext[tailPtr] = 1'b0;
        end
        if (fillValid && fillHit) begin
            dataValidNext[fillIdx] = validNext[fillIdx];
            outstandingNext[fillIdx] = 1'b0;
            ageNext[fillIdx] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            validVec <= '0;
            dataValidVec <= '0;
            outstandingVec <= '0;
            ageVec <= '0;
            headPtr <= '0;
            tailPtr <= '0;
            lookupRespValid <= 1'b0;
        end else begin
            validVec <= validNext;
            dataValidVec <= dataValidNext;
            outstandingVec <= outstandingNext;
            ageVec <= ageNext;
            lookupRespValid <= lookupValid;
            // flush leaves an empty queue starting at the tail
            if (lookupValid) begin
                headPtr <= lookupHit ? lookupIdx : tailPtr;
            end
            if (allocCreate) begin
                tailPtr <= tailPtr + 1'b1;
            end
        end
    end

    // block storage and the registered lookup result
    always_ff @(posedge clk) begin
        if (allocCreate) begin
            addrMat[tailPtr] <= allocAddr;
        end
        if (fillValid && fillHit) begin
            dataMat[fillIdx] <= fill.data;
        end
        if (lookupValid) begin
            lookupResp.hit <= lookupHit;
            lookupResp.dataValid <= lookupHit && dataValidVec[lookupIdx];
            lookupResp.data <= dataMat[lookupIdx];
        end
    end

    // tail slot must be free whenever a new entry is written
    allocNotFull: assert property (@(posedge clk) disable iff (!resetN)
        allocCreate |-> !isFull);
    noPendingData: assert property (@(posedge clk) disable iff (!resetN)
        (validVec & outstandingVec & dataValidVec) == '0);

endmodule

// ==== rtl/prefetchIssuer.sv ====
/* prefetchIssuer: CPU request acceptor and FSM driving next-line allocation
   and the DRAM request */
`timescale 1ns/100ps
`include "prefetcher_macros.svh"

module prefetchIssuer (
    input  logic                      clk,
    input  logic                      resetN,
    input  logic                      cpuReqValid,
    output logic                      cpuReqReady,
    input  prefetcherPkg::cpuReq_t    cpuReq,
    output logic                      lookupValid,
    output prefetcherPkg::blockAddr_t lookupAddr,
    output logic                      allocValid,
    output prefetcherPkg::blockAddr_t allocAddr,
    input  logic                      allocReady,
    input  logic                      allocDup,
    output logic                      dramReqValid,
    input  logic                      dramReqReady,
    output prefetcherPkg::blockAddr_t dramReqAddr
);
    import prefetcherPkg::*;

    issuerState_e state;
    issuerState_e stateNext;
    // block following the one just looked up
    blockAddr_t nextLineAddr;

    always_comb begin
        stateNext = state;
        unique case (state)
            IDLE: begin
                if (cpuReqValid) begin
                    stateNext = ALLOC;
                end
            end
            // a duplicate is already in flight, no DRAM request needed
            ALLOC: begin
                if (allocReady) begin
                    stateNext = allocDup ? IDLE : SEND;
                end
            end
            SEND: begin
                if (dramReqReady) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    // lookup goes to the queue in the same cycle as the CPU transfer
    assign cpuReqReady = (state == IDLE);
    assign lookupValid = cpuReqReady && cpuReqValid;
    assign lookupAddr = cpuReq.addr;
    assign allocValid = (state == ALLOC);
    assign allocAddr = nextLineAddr;
    assign dramReqValid = (state == SEND);
    assign dramReqAddr = nextLineAddr;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            nextLineAddr <= cpuReq.addr + blockAddr_t'(`PF_BLOCK_BYTES);
        end
    end

    dramAddrStable: assert property (@(posedge clk) disable iff (!resetN)
        dramReqValid && !dramReqReady |=> dramReqValid && $stable(dramReqAddr));

endmodule

// ==== rtl/prefetcherTop.sv ====
/* prefetcherTop: issuer and prefetch queue between the CPU miss port and DRAM */
`timescale 1ns/100ps

module prefetcherTop (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       cpuReqValid,
    output logic                       cpuReqReady,
    input  prefetcherPkg::cpuReq_t     cpuReq,
    output logic                       cpuRespValid,
    output prefetcherPkg::lookupResp_t cpuResp,
    output logic                       dramReqValid,
    input  logic                       dramReqReady,
    output prefetcherPkg::blockAddr_t  dramReqAddr,
    input  logic                       fillValid,
    input  prefetcherPkg::dramFill_t   fill,
    input  logic                       invalValid,
    input  prefetcherPkg::blockAddr_t  invalAddr,
    input  prefetcherPkg::prescale_t   watchdogPrescale,
    output prefetcherPkg::queueCnt_t   outstandingReqCnt,
    output logic                       almostFull
);
    import prefetcherPkg::*;

    // issuer to queue
    logic       lookupValid;
    blockAddr_t lookupAddr;
    logic       allocValid;
    blockAddr_t allocAddr;
    logic       allocReady;
    logic       allocDup;

    prefetchIssuer u_issuer (
        .clk(clk), .resetN(resetN),
        .cpuReqValid(cpuReqValid), .cpuReqReady(cpuReqReady), .cpuReq(cpuReq),
        .lookupValid(lookupValid), .lookupAddr(lookupAddr),
        .allocValid(allocValid), .allocAddr(allocAddr),
        .allocReady(allocReady), .allocDup(allocDup),
        .dramReqValid(dramReqValid), .dramReqReady(dramReqReady),
        .dramReqAddr(dramReqAddr));

    prefetcherQueue u_queue (
        .clk(clk), .resetN(resetN),
        .lookupValid(lookupValid), .lookupAddr(lookupAddr),
        .lookupResp(cpuResp), .lookupRespValid(cpuRespValid),
        .allocValid(allocValid), .allocAddr(allocAddr),
        .allocReady(allocReady), .allocDup(allocDup),
        .fillValid(fillValid), .fill(fill),
        .invalValid(invalValid), .invalAddr(invalAddr),
        .watchdogPrescale(watchdogPrescale),
        .outstandingReqCnt(outstandingReqCnt), .almostFull(almostFull));

endmodule

// ==== bench/prefetcherTb.sv ====
/* prefetcherTb: clock, reset, stimulus table, queue reference model,
   response and DRAM request checks, cycle limit */
`timescale 1ns/100ps
`include "prefetcher_macros.svh"

module prefetcherTb;
    import prefetcherPkg::*;

    localparam int NUM_ROWS = 11;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 600;
    localparam int ALMOST_FULL_CNT = `PF_QUEUE_SIZE - `PF_ALMOST_FULL_SPACER;
    // the counter first runs out the period loaded at prescale 200
    localparam int OLD_PERIOD_MAX = 201;
    localparam blockData_t DATA_A = 64'ha5a5_0000_1111_2222;
    localparam blockData_t DATA_B = 64'h0123_4567_89ab_cdef;

    typedef enum logic [1:0] {ROW_READ, ROW_FILL, ROW_INVAL, ROW_IDLE} rowKind_e;

    typedef struct packed {
        rowKind_e   kind;
        blockAddr_t addr;
        blockData_t data;
        prescale_t  prescale;
        logic [7:0] cycles;
        logic       expHit;
        logic       expDataValid;
        blockData_t expData;
        queueCnt_t  expOutstanding;
    } stimRow_t;

    // one queue entry as the model sees it, oldest at the front
    typedef struct packed {
        blockAddr_t addr;
        logic       dataValid;
        logic       outstanding;
        blockData_t data;
    } modelEntry_t;

    logic clk;
    logic resetN;
    logic cpuReqValid;
    logic cpuReqReady;
    cpuReq_t cpuReq;
    logic cpuRespValid;
    lookupResp_t cpuResp;
    logic dramReqValid;
    logic dramReqReady;
    blockAddr_t dramReqAddr;
    logic fillValid;
    dramFill_t fill;
    logic invalValid;
    blockAddr_t invalAddr;
    prescale_t watchdogPrescale;
    queueCnt_t outstandingReqCnt;
    logic almostFull;
    stimRow_t rows [NUM_ROWS];
    modelEntry_t model [$];
    logic [31:0] rngState;
    int cycleCnt = 0;

    prefetcherTop u_prefetcherTop (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("TB FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        assert (got === expected) else reportMismatch(name, got, expected);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // inputs change 2 ns after the edge, outputs are sampled there too
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic int findEntry(input blockAddr_t addr);
        for (int i = 0; i < model.size(); i++) begin
            if (model[i].addr == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int countOutstanding();
        int cnt;
        cnt = 0;
        foreach (model[i]) cnt += model[i].outstanding;
        return cnt;
    endfunction

    // hit pops older entries, miss flushes, then the next line is allocated
    task automatic modelLookup(input blockAddr_t addr, output logic hit,
                               output logic dataValid, output blockData_t data);
        int idx;
        modelEntry_t e;
        idx = findEntry(addr);
        hit = (idx >= 0);
        dataValid = hit ? model[idx].dataValid : 1'b0;
        data = hit ? model[idx].data : '0;
        if (hit) repeat (idx) void'(model.pop_front());
        else model.delete();
        e.addr = addr + `PF_BLOCK_BYTES;
        e.dataValid = 1'b0;
        e.outstanding = 1'b1;
        e.data = '0;
        if (findEntry(e.addr) < 0 && model.size() < ALMOST_FULL_CNT) model.push_back(e);
    endtask

    task automatic modelUpdate(input rowKind_e kind, input blockAddr_t addr,
                               input blockData_t data);
        int idx;
        modelEntry_t e;
        idx = findEntry(addr);
        if (idx >= 0) begin
            e = model[idx];
            e.dataValid = (kind == ROW_FILL);
            if (kind == ROW_FILL) begin
                e.data = data;
                e.outstanding = 1'b0;
            end
            model[idx] = e;
        end
    endtask

    task automatic loadRows();
        rows[0] = '{ROW_READ, 32'h1000, 64'h0, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd1};
        rows[1] = '{ROW_READ, 32'h1008, 64'h0, 10'd200, 8'd0, 1'b1, 1'b0, 64'h0, 4'd2};
        rows[2] = '{ROW_FILL, 32'h1010, DATA_A, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd1};
        rows[3] = '{ROW_READ, 32'h1010, 64'h0, 10'd200, 8'd0, 1'b1, 1'b1, DATA_A, 4'd1};
        rows[4] = '{ROW_FILL, 32'h1018, DATA_B, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd0};
        rows[5] = '{ROW_INVAL, 32'h1018, 64'h0, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd0};
        rows[6] = '{ROW_READ, 32'h1018, 64'h0, 10'd200, 8'd0, 1'b1, 1'b0, 64'h0, 4'd1};
        // break the stream, then the old block is gone
        rows[7] = '{ROW_READ, 32'h5000, 64'h0, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd1};
        rows[8] = '{ROW_READ, 32'h1018, 64'h0, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd1};
        // fast watchdog ages out the pending 0x1020
        rows[9] = '{ROW_IDLE, 32'h0, 64'h0, 10'd4, 8'd230, 1'b0, 1'b0, 64'h0, 4'd0};
        rows[10] = '{ROW_READ, 32'h1020, 64'h0, 10'd200, 8'd0, 1'b0, 1'b0, 64'h0, 4'd1};
    endtask

    initial begin
        stimRow_t row;
        logic mHit;
        logic mDataValid;
        blockData_t mData;
        resetN = 1'b0;
        cpuReqValid = 1'b0;
        cpuReq = '0;
        dramReqReady = 1'b0;
        fillValid = 1'b0;
        fill = '0;
        invalValid = 1'b0;
        invalAddr = '0;
        watchdogPrescale = 10'd200;
        rngState = 32'd77062;
        loadRows();
        repeat (3) @(posedge clk);
        #2 resetN = 1'b1;
        step();
        checkValue("cpuRespValid", cpuRespValid, 1'b0);
        checkValue("dramReqValid", dramReqValid, 1'b0);
        checkValue("outstandingReqCnt", outstandingReqCnt, 4'd0);
        checkValue("almostFull", almostFull, 1'b0);
        checkValue("cpuReqReady", cpuReqReady, 1'b1);
        for (int n = 0; n < NUM_ROWS; n++) begin
            row = rows[n];
            watchdogPrescale = row.prescale;
            case (row.kind)
                ROW_READ: begin
                    cpuReqValid = 1'b1;
                    cpuReq.addr = row.addr;
                    while (!cpuReqReady) step();
                    step();
                    cpuReqValid = 1'b0;
                    modelLookup(row.addr, mHit, mDataValid, mData);
                    assert (mHit == row.expHit && mDataValid == row.expDataValid
                            && (!mDataValid || mData == row.expData))
                    else begin
                        $display("reference model and table disagree on row %0d", n);
                        $display("TB FAILED");
                        $fatal(1, "inconsistent stimulus table");
                    end
                    checkValue("cpuRespValid", cpuRespValid, 1'b1);
                    checkValue("cpuResp.hit", cpuResp.hit, row.expHit);
                    checkValue("cpuResp.dataValid", cpuResp.dataValid, row.expDataValid);
                    if (row.expDataValid) checkValue("cpuResp.data", cpuResp.data, row.expData);
                    // prefetch of the next line, accepted after random back-pressure
                    while (!dramReqValid) step();
                    checkValue("dramReqAddr", dramReqAddr, row.addr + `PF_BLOCK_BYTES);
                    rngState = xorshift32(rngState);
                    repeat (rngState[1:0]) begin
                        step();
                        checkValue("dramReqValid", dramReqValid, 1'b1);
                    end
                    dramReqReady = 1'b1;
                    step();
                    dramReqReady = 1'b0;
                end
                ROW_FILL, ROW_INVAL: begin
                    fillValid = (row.kind == ROW_FILL);
                    fill.addr = row.addr;
                    fill.data = row.data;
                    invalValid = (row.kind == ROW_INVAL);
                    invalAddr = row.addr;
                    step();
                    fillValid = 1'b0;
                    invalValid = 1'b0;
                    modelUpdate(row.kind, row.addr, row.data);
                end
                default: begin
                    repeat (row.cycles) step();
                    // two ticks after the old period has run out evict everything
                    if (row.cycles > OLD_PERIOD_MAX + 2 * (row.prescale + 1) + 2) model.delete();
                end
            endcase
            checkValue("model outstanding", countOutstanding(), row.expOutstanding);
            checkValue("outstandingReqCnt", outstandingReqCnt, row.expOutstanding);
            checkValue("almostFull", almostFull, model.size() >= ALMOST_FULL_CNT);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/prefetcherPkg.sv
rtl/findValueIdx.sv
rtl/watchdogTimer.sv
rtl/prefetcherQueue.sv
rtl/prefetchIssuer.sv
rtl/prefetcherTop.sv
bench/prefetcherTb.sv

// ==== Bender.yml ====
package:
  name: prefetcher

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/prefetcherPkg.sv
  - files:
      - rtl/findValueIdx.sv
      - rtl/watchdogTimer.sv
      - rtl/prefetcherQueue.sv
      - rtl/prefetchIssuer.sv
      - rtl/prefetcherTop.sv
  - target: test
    files:
      - bench/prefetcherTb.sv
